//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = mdio_mgmt_tb
FILELIST  = mdio_mgmt.f
BUILD_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(BUILD_DIR)

//--- bench/mdio_mgmt_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mdio_mgmt_tb;

  localparam logic [4:0] PHY_ADDR = 5'd16;
  localparam int MAX_VECS     = 64;
  localparam int INIT_WRITES  = 7;
  localparam int FRAME_CYCLES = 70;
  localparam int MARGIN       = 200;

  logic        mdc;
  logic        arst_n;
  logic        cmd_valid;
  logic        cmd_ready;
  logic        cmd_read;
  logic [4:0]  cmd_reg;
  logic [15:0] cmd_wdata;
  logic        rsp_valid;
  logic        rsp_ready;
  logic [15:0] rsp_rdata;
  logic        mdio_o;
  logic        mdio_oe;
  wire         mdio_i;
  logic        init_done;

  // four words per vector in file column order
  logic [15:0] vec_mem [4 * MAX_VECS];
  int          vec_cnt = 0;
  int          host_writes = 0;
  int          err_cnt = 0;
  int          check_cnt = 0;
  int          cycle_cnt = 0;
  int          cycle_limit = 0;
  int          frames_checked = 0;
  int          reads_seen = 0;
  // {read, reg, data} in the order the PHY should see them
  logic [21:0] frame_q [$];
  logic [15:0] rsp_q [$];

  mdio_mgmt_top #(
    .PHY_ADDR  (PHY_ADDR),
    .CMD_DEPTH (4),
    .RSP_DEPTH (4)
  ) uut (
    .mdc       (mdc),
    .arst_n    (arst_n),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd_read  (cmd_read),
    .cmd_reg   (cmd_reg),
    .cmd_wdata (cmd_wdata),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_rdata (rsp_rdata),
    .mdio_o    (mdio_o),
    .mdio_oe   (mdio_oe),
    .mdio_i    (mdio_i),
    .init_done (init_done)
  );

  mdio_phy_model #(
    .PHY_ADDR (PHY_ADDR)
  ) phy (
    .mdc     (mdc),
    .mdio_o  (mdio_o),
    .mdio_oe (mdio_oe),
    .mdio_i  (mdio_i)
  );

  initial
  begin
    mdc = 1'b0;
    forever #20 mdc = ~mdc;
  end

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
    check_cnt++;
    if (got !== expected)
    begin
      err_cnt++;
      $display("FAIL %0t ns %s got %h expected %h", $time, name, got, expected);
    end
  endtask

  task automatic report_error(input string why);
    err_cnt++;
    $display("ERROR at %0t ns: %s", $time, why);
  endtask

  task automatic load_vectors();
    $readmemh("bench/mdio_mgmt_vectors.txt", vec_mem);
    while (vec_cnt < MAX_VECS && vec_mem[4 * vec_cnt] !== 16'h000f)
      vec_cnt++;
    if (vec_cnt == MAX_VECS)
    begin
      report_error("vector file has no end marker");
      vec_cnt = 0;
    end
  endtask

  // called 2 ns after a rising edge and returns 2 ns after the accepting edge
  task automatic send_cmd(input logic rd, input logic [4:0] ra, input logic [15:0] wd);
    logic taken;
    taken     = 1'b0;
    cmd_valid = 1'b1;
    cmd_read  = rd;
    cmd_reg   = ra;
    cmd_wdata = wd;
    while (!taken)
    begin
      @(negedge mdc);
      taken = cmd_ready;
      @(posedge mdc);
    end
    #2;
    cmd_valid = 1'b0;
  endtask

  task automatic drive_vectors();
    logic        rd;
    logic [4:0]  ra;
    logic [15:0] wd;
    logic [15:0] rd_expected;
    for (int i = 0; i < vec_cnt; i++)
    begin
      rd          = vec_mem[4 * i][0];
      ra          = vec_mem[4 * i + 1][4:0];
      wd          = vec_mem[4 * i + 2];
      rd_expected = vec_mem[4 * i + 3];
      frame_q.push_back({rd, ra, rd ? rd_expected : wd});
      if (rd)
        rsp_q.push_back(rd_expected);
      else
        host_writes++;
      send_cmd(rd, ra, wd);
    end
  endtask

  // first result waits in the response queue until the second read is back
  task automatic hold_responses();
    @(negedge mdc);
    while (!rsp_valid)
      @(negedge mdc);
    while (reads_seen < 2)
    begin
      @(negedge mdc);
      compare_value("rsp_valid", 32'(rsp_valid), 32'd1);
    end
    // second result is pushed on the next edge
    repeat (2) @(posedge mdc);
    #2;
    rsp_ready = 1'b1;
  endtask

  // every frame the PHY decodes has to be the next one expected
  always @(posedge mdc)
  begin
    if (phy.frame_cnt != frames_checked)
    begin
      if (frame_q.size() == 0)
        report_error("PHY decoded a frame that was never issued");
      else
        compare_value("phy frame {read,reg,data}",
                      32'({phy.last_read, phy.last_reg, phy.last_data}),
                      32'(frame_q.pop_front()));
      if (frames_checked < INIT_WRITES)
        compare_value("init_done", 32'(init_done),
                      32'(frames_checked == INIT_WRITES - 1));
      if (phy.last_read)
        reads_seen++;
      frames_checked++;
    end
  end

  // values here are the ones the next rising edge takes
  always @(negedge mdc)
  begin
    if (rsp_valid && rsp_ready)
    begin
      if (rsp_q.size() == 0)
        report_error("read response with no read outstanding");
      else
        compare_value("rsp_rdata", 32'(rsp_rdata), 32'(rsp_q.pop_front()));
    end
  end

  always @(posedge mdc)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
    begin
      $display("timeout after %0d cycles, frames or responses still missing", cycle_cnt);
      $display("Simulation failed");
      $finish;
    end
  end

  initial
  begin
    arst_n    = 1'b0;
    cmd_valid = 1'b0;
    cmd_read  = 1'b0;
    cmd_reg   = '0;
    cmd_wdata = '0;
    rsp_ready = 1'b0;
    load_vectors();
    // 65 cycles per frame rounded up per command
    cycle_limit = (INIT_WRITES + vec_cnt) * FRAME_CYCLES + MARGIN;
    // bring-up writes come out first in table order
    frame_q.push_back({1'b0, 5'd16, 16'h0060});
    frame_q.push_back({1'b0, 5'd0,  16'h8140});
    frame_q.push_back({1'b0, 5'd20, 16'h0070});
    frame_q.push_back({1'b0, 5'd0,  16'h8140});
    frame_q.push_back({1'b0, 5'd29, 16'h0012});
    frame_q.push_back({1'b0, 5'd30, 16'h8240});
    frame_q.push_back({1'b0, 5'd0,  16'h8140});
    repeat (3) @(posedge mdc);
    #2;
    compare_value("mdio_oe", 32'(mdio_oe), 32'd0);
    compare_value("mdio_o", 32'(mdio_o), 32'd1);
    compare_value("cmd_ready", 32'(cmd_ready), 32'd1);
    compare_value("init_done", 32'(init_done), 32'd0);
    compare_value("rsp_valid", 32'(rsp_valid), 32'd0);
    arst_n = 1'b1;
    fork
      drive_vectors();
      hold_responses();
    join
    while (frame_q.size() != 0 || rsp_q.size() != 0)
      @(posedge mdc);
    compare_value("phy bad frames", 32'(phy.bad_cnt), 32'd0);
    compare_value("phy write count", 32'(phy.write_cnt), 32'(INIT_WRITES + host_writes));
    $display("checks %0d, errors %0d, frames %0d, bad frames %0d",
             check_cnt, err_cnt, frames_checked, phy.bad_cnt);
    if (err_cnt == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/mdio_mgmt_vectors.txt
// read flag, register, write data, expected read data (all hex)
// a read flag of f ends the list
1 10 0000 0060
1 14 0000 0070
1 1d 0000 0012
1 1e 0000 8240
1 00 0000 8140
0 05 a5c3 0000
1 05 0000 a5c3
0 10 1234 0000
1 10 0000 1234
0 1f ffff 0000
1 1f 0000 ffff
0 04 0001 0000
1 04 0000 0001
1 07 0000 0000
0 00 0000 0000
1 00 0000 0000
0 1e 5a5a 0000
1 1e 0000 5a5a
f 00 0000 0000

//--- bench/mdio_phy_model.sv
`timescale 1ns/1ps
`default_nettype none

// behavioral clause 22 PHY, watches the station pins and answers reads
module mdio_phy_model #(
  parameter logic [4:0] PHY_ADDR = 5'd0
) (
  input  wire mdc,
  input  wire mdio_o,
  input  wire mdio_oe,
  output wire mdio_i
);

  logic [15:0] regs [32] = '{default: 16'h0000};
  logic        drive_bit = 1'b1;
  logic [13:0] hdr = '0;
  logic [15:0] wr_data = '0;
  logic        rd = 1'b0;
  int          ones = 0;
  // -1 while hunting for preamble and start
  int          bit_idx = -1;
  int          frame_cnt = 0;
  int          write_cnt = 0;
  int          bad_cnt = 0;
  logic        last_read = 1'b0;
  logic [4:0]  last_reg = '0;
  logic [15:0] last_data = '0;

  assign mdio_i = drive_bit;

  task automatic flag_bad(input string why);
    bad_cnt++;
    $display("PHY model at %0t ns: %s", $time, why);
  endtask

  // sampled mid-cycle, the station moves the line on the rising edge
  always @(negedge mdc)
  begin
    if (bit_idx < 0)
    begin
      drive_bit = 1'b1;
      if (mdio_oe && mdio_o)
        ones++;
      else if (mdio_oe && ones >= 32)
      begin
        // first start bit seen, it lands in hdr[13]
        hdr     = '0;
        bit_idx = 1;
      end
      else
      begin
        if (mdio_oe)
          flag_bad("start bit after a short preamble");
        ones = 0;
      end
    end
    else
    begin
      if (bit_idx < 14)
      begin
        if (!mdio_oe)
          flag_bad("line released inside the frame header");
        hdr = {hdr[12:0], mdio_o};
      end
      else
      begin
        rd = (hdr[11:10] == 2'b10);
        if (bit_idx == 14 && (hdr[13:12] != 2'b01 || (!rd && hdr[11:10] != 2'b01)))
          flag_bad("bad start or opcode field");
        if (rd && mdio_oe)
          flag_bad("station drives the line during read turnaround or data");
        if (!rd && (!mdio_oe || (bit_idx == 14 && !mdio_o) || (bit_idx == 15 && mdio_o)))
          flag_bad("bad write turnaround or released write data");
        // data bit goes out msb first, ready before the next rising edge
        if (rd && bit_idx >= 16 && hdr[9:5] == PHY_ADDR)
          drive_bit = regs[hdr[4:0]][31 - bit_idx];
        wr_data = {wr_data[14:0], mdio_o};
      end
      if (bit_idx == 31)
      begin
        if (hdr[9:5] == PHY_ADDR)
        begin
          if (!rd)
          begin
            regs[hdr[4:0]] = wr_data;
            write_cnt++;
          end
          last_read = rd;
          last_reg  = hdr[4:0];
          last_data = regs[hdr[4:0]];
          frame_cnt++;
        end
        bit_idx = -1;
        ones    = 0;
      end
      else
        bit_idx++;
    end
  end

endmodule

`default_nettype wire

//--- design/mdio_cmd_if.sv
`timescale 1ns/1ps
`default_nettype none

// command handshake, source holds cmd while valid is high
interface mdio_cmd_if;

  import mdio_frame_pkg::*;

  logic      valid;
  logic      ready;
  mdio_cmd_t cmd;

  modport src (
    output valid,
    output cmd,
    input  ready
  );

  modport dst (
    input  valid,
    input  cmd,
    output ready
  );

endinterface

`default_nettype wire

//--- design/mdio_frame_engine.sv
`timescale 1ns/1ps
`default_nettype none

module mdio_frame_engine #(
  parameter logic [4:0] PHY_ADDR = 5'd0
) (
  input  wire                       mdc,
  input  wire                       arst_n,
  mdio_cmd_if.dst                   cmd,
  output logic                      rsp_valid,
  input  wire                       rsp_ready,
  output mdio_frame_pkg::reg_data_t rsp_data,
  output logic                      mdio_o,
  output logic                      mdio_oe,
  input  wire                       mdio_i
);

  import mdio_frame_pkg::*;

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_PREAMBLE,
    ST_START,
    ST_OPCODE,
    ST_PHY_ADDR,
    ST_REG_ADDR,
    ST_TURNAROUND,
    ST_DATA,
    ST_RESPOND
  } state_t;

  state_t    state;
  state_t    next_state;
  logic [4:0] bit_cnt;
  logic [4:0] next_cnt;
  reg_data_t sh;
  reg_data_t next_sh;
  mdio_cmd_t cmd_r;
  logic      accept;
  logic      in_frame;
  logic      shift_in;

  assign cmd.ready = (state == ST_IDLE) || (state == ST_RESPOND && rsp_ready);
  assign accept    = cmd.valid && cmd.ready;
  assign in_frame  = (state != ST_IDLE) && (state != ST_RESPOND);
  // ones fill the register outside the data field
  assign shift_in  = (state == ST_DATA) ? mdio_i : 1'b1;

  assign rsp_valid = (state == ST_RESPOND);
  assign rsp_data  = sh;

  // line is only driven while a field belongs to the station
  always_comb
  begin
    case (state)
      ST_PREAMBLE, ST_START, ST_OPCODE, ST_PHY_ADDR, ST_REG_ADDR:
        mdio_oe = 1'b1;
      ST_TURNAROUND, ST_DATA:
        mdio_oe = !cmd_r.read;
      default:
        mdio_oe = 1'b0;
    endcase
  end

  assign mdio_o = mdio_oe ? sh[15] : 1'b1;

  // next field, its length minus one, and its bits left justified
  always_comb
  begin
    next_state = ST_IDLE;
    next_cnt   = '0;
    next_sh    = {sh[14:0], shift_in};
    case (state)
      ST_PREAMBLE:
      begin
        next_state = ST_START;
        next_cnt   = 5'd1;
        next_sh    = {ST_BITS, 14'b0};
      end
      ST_START:
      begin
        next_state = ST_OPCODE;
        next_cnt   = 5'd1;
        next_sh    = {(cmd_r.read ? OP_READ : OP_WRITE), 14'b0};
      end
      ST_OPCODE:
      begin
        next_state = ST_PHY_ADDR;
        next_cnt   = 5'd4;
        next_sh    = {PHY_ADDR, 11'b0};
      end
      ST_PHY_ADDR:
      begin
        next_state = ST_REG_ADDR;
        next_cnt   = 5'd4;
        next_sh    = {cmd_r.addr, 11'b0};
      end
      ST_REG_ADDR:
      begin
        next_state = ST_TURNAROUND;
        next_cnt   = 5'd1;
        next_sh    = {TA_WRITE, 14'b0};
      end
      ST_TURNAROUND:
      begin
        next_state = ST_DATA;
        next_cnt   = 5'd15;
        next_sh    = cmd_r.wdata;
      end
      ST_DATA:
        next_state = cmd_r.read ? ST_RESPOND : ST_IDLE;
      default:
        next_state = ST_IDLE;
    endcase
  end

  always_ff @(posedge mdc or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state   <= ST_IDLE;
      bit_cnt <= '0;
    end
    else if (accept)
    begin
      state   <= ST_PREAMBLE;
      bit_cnt <= 5'(PREAMBLE_BITS - 1);
    end
    else if (state == ST_RESPOND)
    begin
      // waits here while the response queue is full
      if (rsp_ready)
        state <= ST_IDLE;
    end
    else if (in_frame)
    begin
      if (bit_cnt == '0)
      begin
        state   <= next_state;
        bit_cnt <= next_cnt;
      end
      else
        bit_cnt <= bit_cnt - 1'b1;
    end
  end

  // read data collects in sh and stays there for the response
  always_ff @(posedge mdc)
  begin
    if (accept)
    begin
      cmd_r <= cmd.cmd;
      sh    <= '1;
    end
    else if (in_frame)
      sh <= (bit_cnt == '0) ? next_sh : {sh[14:0], shift_in};
  end

  // every frame keeps the engine busy for all of its bits
  a_frame_len: assert property (@(posedge mdc) disable iff (!arst_n)
    accept |=> !cmd.ready [*FRAME_BITS]);

  // released for turnaround and all read data bits
  a_read_release: assert property (@(posedge mdc) disable iff (!arst_n)
    (accept && cmd.cmd.read) |->
      ##(FRAME_BITS - $bits(reg_data_t) - 1) !mdio_oe [*($bits(reg_data_t) + 2)]);

endmodule

`default_nettype wire

//--- design/mdio_frame_pkg.sv
`default_nettype none

package mdio_frame_pkg;

  // clause 22 frame fields, sent msb first
  localparam int PREAMBLE_BITS = 32;

  localparam logic [1:0] ST_BITS = 2'b01;

  localparam logic [1:0] OP_WRITE = 2'b01;
  localparam logic [1:0] OP_READ  = 2'b10;

  // only the station drives turnaround on writes
  localparam logic [1:0] TA_WRITE = 2'b10;

  typedef logic [4:0] reg_addr_t;

  typedef logic [15:0] reg_data_t;

  // one management transaction, phy address comes from the top
  typedef struct packed {
    logic      read;
    reg_addr_t addr;
    reg_data_t wdata;
  } mdio_cmd_t;

  // preamble, start, opcode, two addresses, turnaround, data
  localparam int FRAME_BITS = PREAMBLE_BITS
                            + $bits(ST_BITS)
                            + $bits(OP_WRITE)
                            + 2 * $bits(reg_addr_t)
                            + $bits(TA_WRITE)
                            + $bits(reg_data_t);

endpackage

`default_nettype wire

//--- design/mdio_mgmt_top.sv
`timescale 1ns/1ps
`default_nettype none

module mdio_mgmt_top #(
  parameter logic [4:0] PHY_ADDR  = 5'd0,
  parameter int         CMD_DEPTH = 4,
  parameter int         RSP_DEPTH = 4
) (
  input  wire                       mdc,
  input  wire                       arst_n,
  input  wire                       cmd_valid,
  output logic                      cmd_ready,
  input  wire                       cmd_read,
  input  mdio_frame_pkg::reg_addr_t cmd_reg,
  input  mdio_frame_pkg::reg_data_t cmd_wdata,
  output logic                      rsp_valid,
  input  wire                       rsp_ready,
  output mdio_frame_pkg::reg_data_t rsp_rdata,
  output logic                      mdio_o,
  output logic                      mdio_oe,
  input  wire                       mdio_i,
  output logic                      init_done
);

  import mdio_frame_pkg::*;

  mdio_cmd_t host_cmd;
  logic      eng_rsp_valid;
  logic      eng_rsp_ready;
  reg_data_t eng_rsp_data;

  mdio_cmd_if host_q_if ();
  mdio_cmd_if eng_if ();

  assign host_cmd = '{read: cmd_read, addr: cmd_reg, wdata: cmd_wdata};

  // host commands wait here while the init table runs
  mgmt_fifo #(
    .payload_t (mdio_cmd_t),
    .DEPTH     (CMD_DEPTH)
  ) cmd_q (
    .mdc       (mdc),
    .arst_n    (arst_n),
    .in_valid  (cmd_valid),
    .in_ready  (cmd_ready),
    .in_data   (host_cmd),
    .out_valid (host_q_if.valid),
    .out_ready (host_q_if.ready),
    .out_data  (host_q_if.cmd)
  );

  phy_init_seq u_init_seq (
    .mdc       (mdc),
    .arst_n    (arst_n),
    .host      (host_q_if),
    .eng       (eng_if),
    .init_done (init_done)
  );

  mdio_frame_engine #(
    .PHY_ADDR (PHY_ADDR)
  ) u_engine (
    .mdc       (mdc),
    .arst_n    (arst_n),
    .cmd       (eng_if),
    .rsp_valid (eng_rsp_valid),
    .rsp_ready (eng_rsp_ready),
    .rsp_data  (eng_rsp_data),
    .mdio_o    (mdio_o),
    .mdio_oe   (mdio_oe),
    .mdio_i    (mdio_i)
  );

  // read results in issue order
  mgmt_fifo #(
    .payload_t (reg_data_t),
    .DEPTH     (RSP_DEPTH)
  ) rsp_q (
    .mdc       (mdc),
    .arst_n    (arst_n),
    .in_valid  (eng_rsp_valid),
    .in_ready  (eng_rsp_ready),
    .in_data   (eng_rsp_data),
    .out_valid (rsp_valid),
    .out_ready (rsp_ready),
    .out_data  (rsp_rdata)
  );

endmodule

`default_nettype wire

//--- design/mgmt_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module mgmt_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  wire      mdc,
  input  wire      arst_n,
  input  wire      in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  wire      out_ready,
  output payload_t out_data
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  payload_t        mem [DEPTH];
  logic [AW - 1:0] wr_ptr;
  logic [AW - 1:0] rd_ptr;
  logic [CW - 1:0] count;
  logic            push;
  logic            pop;

  assign in_ready  = (count != CW'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge mdc)
  begin
    if (push)
      mem[wr_ptr] <= in_data;
  end

  always_ff @(posedge mdc or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  // empty or full means the pointers met, anything else is an overrun
  a_ptr_meet: assert property (@(posedge mdc) disable iff (!arst_n)
    (count == '0 || count == CW'(DEPTH)) |-> (wr_ptr == rd_ptr));

  // head entry waits unchanged under back-pressure
  a_hold: assert property (@(posedge mdc) disable iff (!arst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data)));

endmodule

`default_nettype wire

//--- design/phy_init_pkg.sv
`default_nettype none

package phy_init_pkg;

  import mdio_frame_pkg::*;

  localparam int INIT_COUNT = 7;

  typedef mdio_cmd_t init_entry_t;

  // counts 0..INIT_COUNT, the last value means done
  typedef logic [$clog2(INIT_COUNT + 1) - 1:0] init_idx_t;

  // phy bring-up writes, replayed in order after reset
  localparam init_entry_t INIT_TABLE [INIT_COUNT] = '{
    '{read: 1'b0, addr: 5'd16, wdata: 16'h0060},
    '{read: 1'b0, addr: 5'd0,  wdata: 16'h8140},
    '{read: 1'b0, addr: 5'd20, wdata: 16'h0070},
    '{read: 1'b0, addr: 5'd0,  wdata: 16'h8140},
    '{read: 1'b0, addr: 5'd29, wdata: 16'h0012},
    '{read: 1'b0, addr: 5'd30, wdata: 16'h8240},
    '{read: 1'b0, addr: 5'd0,  wdata: 16'h8140}
  };

endpackage

`default_nettype wire

//--- design/phy_init_seq.sv
`timescale 1ns/1ps
`default_nettype none

module phy_init_seq (
  input  wire        mdc,
  input  wire        arst_n,
  mdio_cmd_if.dst    host,
  mdio_cmd_if.src    eng,
  output logic       init_done
);

  import phy_init_pkg::*;

  init_idx_t entry_idx;
  logic      init_xfer;

  assign init_done = (entry_idx == init_idx_t'(INIT_COUNT));
  assign init_xfer = !init_done && eng.valid && eng.ready;

  // table first and then host commands straight through
  always_comb
  begin
    if (init_done)
    begin
      eng.valid  = host.valid;
      eng.cmd    = host.cmd;
      host.ready = eng.ready;
    end
    else
    begin
      eng.valid  = 1'b1;
      eng.cmd    = INIT_TABLE[entry_idx];
      host.ready = 1'b0;
    end
  end

  always_ff @(posedge mdc or negedge arst_n)
  begin
    if (!arst_n)
      entry_idx <= '0;
    else if (init_xfer)
      entry_idx <= entry_idx + 1'b1;
  end

  // stays high for the rest of the run
  a_done_sticky: assert property (@(posedge mdc) disable iff (!arst_n)
    init_done |=> init_done);

  // engine sees a stable command until it takes it
  a_eng_stable: assert property (@(posedge mdc) disable iff (!arst_n)
    (eng.valid && !eng.ready) |=> (eng.valid && $stable(eng.cmd)));

endmodule

`default_nettype wire

//--- mdio_mgmt.f
design/mdio_frame_pkg.sv
design/phy_init_pkg.sv
design/mdio_cmd_if.sv
design/mgmt_fifo.sv
design/phy_init_seq.sv
design/mdio_frame_engine.sv
design/mdio_mgmt_top.sv
bench/mdio_phy_model.sv
bench/mdio_mgmt_tb.sv
